//--- Bender.yml
package:
  name: decodeExecute

sources:
  - files:
      - src/rvPkg.sv
      - src/instrDecoder.sv
      - src/regFile.sv
      - src/decodeExecReg.sv
      - src/execUnit.sv
      - src/decodeExecute.sv
  - target: test
    files:
      - tests/tbClock.sv
      - tests/decodeExecute_properties.sv
      - tests/decodeExecute_tb.sv

//--- decodeExecute.f
src/rvPkg.sv
src/instrDecoder.sv
src/regFile.sv
src/decodeExecReg.sv
src/execUnit.sv
src/decodeExecute.sv
tests/tbClock.sv
tests/decodeExecute_properties.sv
tests/decodeExecute_tb.sv

//--- src/decodeExecReg.sv
`timescale 1ns/1ns

module decodeExecReg import rvPkg::*; #(
    parameter logic [xlen-1:0] resetPc = '0
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     flush,
    input  deBundleT deIn,
    output deBundleT deOut
);

    // Empty slot: no valid, no control, zero data
    function automatic deBundleT makeBubble();
        deBundleT b;
        b    = '0;
        b.pc = resetPc;
        return b;
    endfunction

    localparam deBundleT bubble = makeBubble();

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            deOut <= bubble;
        end else if (flush) begin
            deOut <= bubble; // Younger instruction squashed by a redirect
        end else begin
            deOut <= deIn;
        end
    end

endmodule

//--- src/decodeExecute.sv
`timescale 1ns/1ns

module decodeExecute import rvPkg::*; #(
    parameter logic [xlen-1:0] resetPc = 32'h0000_0000
) (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic                    instrValid,
    input  logic [xlen-1:0]         instr,
    input  logic [xlen-1:0]         pc,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [xlen-1:0]         wbData,
    output exResultT                exOut,
    output logic                    redirect,
    output logic [xlen-1:0]         redirectPc
);

    ctrlWordT                ctrl;
    logic [regAddrWidth-1:0] rs1;
    logic [regAddrWidth-1:0] rs2;
    logic [regAddrWidth-1:0] rd;
    logic [xlen-1:0]         imm;
    logic [xlen-1:0]         rs1Data;
    logic [xlen-1:0]         rs2Data;
    deBundleT                deIn;
    deBundleT                deOut;

    instrDecoder uDecoder (
        .instr (instr),
        .ctrl  (ctrl),
        .rs1   (rs1),
        .rs2   (rs2),
        .rd    (rd),
        .imm   (imm)
    );

    regFile uRegFile (
        .clk     (clk),
        .arstN   (arstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData)
    );

    always_comb begin
        deIn.valid   = instrValid;
        deIn.ctrl    = instrValid ? ctrl : '0; // Idle cycles carry no control
        deIn.rs1Data = rs1Data;
        deIn.rs2Data = rs2Data;
        deIn.pc      = pc;
        deIn.pcPlus4 = pc + xlen'(4);
        deIn.imm     = imm;
        deIn.rs1     = rs1;
        deIn.rs2     = rs2;
        deIn.rd      = rd;
    end

    decodeExecReg #(
        .resetPc (resetPc)
    ) uDeReg (
        .clk   (clk),
        .arstN (arstN),
        .flush (redirect),
        .deIn  (deIn),
        .deOut (deOut)
    );

    execUnit uExec (
        .deOut      (deOut),
        .exOut      (exOut),
        .redirect   (redirect),
        .redirectPc (redirectPc)
    );

endmodule

//--- src/execUnit.sv
`timescale 1ns/1ns

module execUnit import rvPkg::*; (
    input  deBundleT        deOut,
    output exResultT        exOut,
    output logic            redirect,
    output logic [xlen-1:0] redirectPc
);

    logic [xlen-1:0] opA;
    logic [xlen-1:0] opB;
    logic [xlen-1:0] aluResult;
    logic [4:0]      shamt;
    logic            taken;
    logic [xlen-1:0] jalrTarget;

    assign opA   = deOut.rs1Data;
    assign opB   = deOut.ctrl.aluSrcImm ? deOut.imm : deOut.rs2Data;
    assign shamt = opB[4:0];

    always_comb begin
        case (deOut.ctrl.aluOp)
            aluAdd:   aluResult = opA + opB;
            aluSub:   aluResult = opA - opB;
            aluAnd:   aluResult = opA & opB;
            aluOr:    aluResult = opA | opB;
            aluXor:   aluResult = opA ^ opB;
            aluSlt:   aluResult = {{(xlen-1){1'b0}}, $signed(opA) < $signed(opB)};
            aluSltu:  aluResult = {{(xlen-1){1'b0}}, opA < opB};
            aluSll:   aluResult = opA << shamt;
            aluSrl:   aluResult = opA >> shamt;
            aluSra:   aluResult = $signed(opA) >>> shamt;
            aluPassB: aluResult = opB;
            default:  aluResult = '0;
        endcase
    end

    // Branch comparator on the register operands
    always_comb begin
        case (deOut.ctrl.branchFunct)
            3'b000:  taken = deOut.rs1Data == deOut.rs2Data;                   // beq
            3'b001:  taken = deOut.rs1Data != deOut.rs2Data;                   // bne
            3'b100:  taken = $signed(deOut.rs1Data) < $signed(deOut.rs2Data);  // blt
            3'b101:  taken = $signed(deOut.rs1Data) >= $signed(deOut.rs2Data); // bge
            3'b110:  taken = deOut.rs1Data < deOut.rs2Data;                    // bltu
            3'b111:  taken = deOut.rs1Data >= deOut.rs2Data;                   // bgeu
            default: taken = 1'b0;
        endcase
    end

    assign jalrTarget = deOut.rs1Data + deOut.imm;

    assign redirect = deOut.valid &&
                      (deOut.ctrl.jump || (deOut.ctrl.branch && taken));

    always_comb begin
        if (deOut.ctrl.jumpReg) begin
            redirectPc = {jalrTarget[xlen-1:1], 1'b0}; // Bit 0 cleared per JALR
        end else begin
            redirectPc = deOut.pc + deOut.imm;
        end
    end

    always_comb begin
        exOut.valid     = deOut.valid;
        exOut.regWrite  = deOut.ctrl.regWrite;
        exOut.memRead   = deOut.ctrl.memRead;
        exOut.memWrite  = deOut.ctrl.memWrite;
        exOut.resultSrc = deOut.ctrl.resultSrc;
        exOut.aluResult = aluResult;
        exOut.storeData = deOut.rs2Data;
        exOut.pcPlus4   = deOut.pcPlus4; // Link value for JAL and JALR
        exOut.rd        = deOut.rd;
    end

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/1ns

module instrDecoder import rvPkg::*; (
    input  logic [xlen-1:0]         instr,
    output ctrlWordT                ctrl,
    output logic [regAddrWidth-1:0] rs1,
    output logic [regAddrWidth-1:0] rs2,
    output logic [regAddrWidth-1:0] rd,
    output logic [xlen-1:0]         imm
);

    opcodeT     opcode;
    logic [2:0] funct3;
    logic       altBit;  // instr[30], selects sub and sra

    assign opcode = opcodeT'(instr[6:0]);
    assign funct3 = instr[14:12];
    assign altBit = instr[30];

    assign rs1 = instr[19:15];
    assign rs2 = instr[24:20];
    // Stores, branches and unknown opcodes carry no destination
    assign rd  = ctrl.regWrite ? instr[11:7] : '0;

    function automatic aluOpT functToAlu(input logic [2:0] f3, input logic alt);
        aluOpT op;
        case (f3)
            3'b000:  op = alt ? aluSub : aluAdd;
            3'b001:  op = aluSll;
            3'b010:  op = aluSlt;
            3'b011:  op = aluSltu;
            3'b100:  op = aluXor;
            3'b101:  op = alt ? aluSra : aluSrl;
            3'b110:  op = aluOr;
            default: op = aluAnd;
        endcase
        return op;
    endfunction

    always_comb begin
        ctrl = '0;
        case (opcode)
            opReg: begin
                ctrl.regWrite = 1'b1;
                ctrl.aluOp    = functToAlu(funct3, altBit);
            end
            opImm: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                // addi has no subtract form, only srai uses bit 30
                ctrl.aluOp     = functToAlu(funct3, (funct3 == 3'b101) && altBit);
            end
            opLoad: begin
                ctrl.regWrite  = 1'b1;
                ctrl.memRead   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSrc = resMem;
            end
            opStore: begin
                ctrl.memWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
            end
            opBranch: begin
                ctrl.branch      = 1'b1;
                ctrl.branchFunct = funct3;
            end
            opJal: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.resultSrc = resPcPlus4;
            end
            opJalr: begin
                ctrl.regWrite  = 1'b1;
                ctrl.jump      = 1'b1;
                ctrl.jumpReg   = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.resultSrc = resPcPlus4;
            end
            opLui: begin
                ctrl.regWrite  = 1'b1;
                ctrl.aluSrcImm = 1'b1;
                ctrl.aluOp     = aluPassB;
            end
            default: ctrl = '0; // Illegal opcode, acts as a bubble
        endcase
    end

    // Immediate formats, all sign extended from bit 31
    always_comb begin
        case (opcode)
            opStore:
                imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            opBranch:
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            opJal:
                imm = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                       instr[30:21], 1'b0};
            opLui:
                imm = {instr[31:12], 12'b0};
            default:
                imm = {{20{instr[31]}}, instr[31:20]}; // I-type
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/1ns

module regFile import rvPkg::*; (
    input  logic                    clk,
    input  logic                    arstN,
    input  logic [regAddrWidth-1:0] rs1,
    input  logic [regAddrWidth-1:0] rs2,
    output logic [xlen-1:0]         rs1Data,
    output logic [xlen-1:0]         rs2Data,
    input  logic                    wbEn,
    input  logic [regAddrWidth-1:0] wbAddr,
    input  logic [xlen-1:0]         wbData
);

    localparam int numRegs = 2 ** regAddrWidth;

    logic [xlen-1:0] regs [numRegs];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < numRegs; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (wbAddr != '0)) begin // x0 stays zero
            regs[wbAddr] <= wbData;
        end
    end

    // No write bypass, a write is seen from the next cycle on
    assign rs1Data = regs[rs1];
    assign rs2Data = regs[rs2];

endmodule

//--- src/rvPkg.sv
package rvPkg;

    parameter int xlen = 32;
    parameter int regAddrWidth = 5;

    // Major opcodes, encoded as the 7-bit opcode field
    typedef enum logic [6:0] {
        opReg    = 7'b0110011,
        opImm    = 7'b0010011,
        opLoad   = 7'b0000011,
        opStore  = 7'b0100011,
        opBranch = 7'b1100011,
        opJal    = 7'b1101111,
        opJalr   = 7'b1100111,
        opLui    = 7'b0110111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluAnd   = 4'd2,
        aluOr    = 4'd3,
        aluXor   = 4'd4,
        aluSlt   = 4'd5,
        aluSltu  = 4'd6,
        aluSll   = 4'd7,
        aluSrl   = 4'd8,
        aluSra   = 4'd9,
        aluPassB = 4'd10 // Operand B straight through, used by LUI
    } aluOpT;

    typedef enum logic [1:0] {
        resAlu     = 2'd0,
        resMem     = 2'd1,
        resPcPlus4 = 2'd2
    } resultSrcT;

    typedef struct packed {
        logic      regWrite;
        logic      memRead;
        logic      memWrite;
        logic      branch;
        logic      jump;
        logic      jumpReg;    // JALR, target from rs1
        logic      aluSrcImm;
        resultSrcT resultSrc;
        aluOpT     aluOp;
        logic [2:0] branchFunct; // funct3 of a branch
    } ctrlWordT;

    typedef struct packed {
        logic                    valid;
        ctrlWordT                ctrl;
        logic [xlen-1:0]         rs1Data;
        logic [xlen-1:0]         rs2Data;
        logic [xlen-1:0]         pc;
        logic [xlen-1:0]         pcPlus4;
        logic [xlen-1:0]         imm;
        logic [regAddrWidth-1:0] rs1;
        logic [regAddrWidth-1:0] rs2;
        logic [regAddrWidth-1:0] rd;
    } deBundleT;

    typedef struct packed {
        logic                    valid;
        logic                    regWrite;
        logic                    memRead;
        logic                    memWrite;
        resultSrcT               resultSrc;
        logic [xlen-1:0]         aluResult;
        logic [xlen-1:0]         storeData;
        logic [xlen-1:0]         pcPlus4;
        logic [regAddrWidth-1:0] rd;
    } exResultT;

endpackage

//--- tests/decodeExecute_properties.sv
`timescale 1ns/1ns

module decodeExecute_properties import rvPkg::*; (
    input logic     clk,
    input logic     arstN,
    input logic     flush,
    input deBundleT deOut,
    input exResultT exOut,
    input logic     redirect
);

    int failCount = 0; // Failed assertion count

    // A flushed slot must come out as a bubble
    flushGivesBubble: assert property (
        @(posedge clk) disable iff (!arstN) flush |=> !deOut.valid
    ) else begin
        $error("flush edge left a valid instruction in the pipeline register");
        failCount = failCount + 1;
    end

    redirectNeedsValid: assert property (
        @(posedge clk) disable iff (!arstN) !deOut.valid |-> !redirect
    ) else begin
        $error("redirect raised by an empty slot");
        failCount = failCount + 1;
    end

    // Stores and branches have rd zeroed by the decoder
    noStrayRd: assert property (
        @(posedge clk) disable iff (!arstN)
            !(exOut.valid && !exOut.regWrite && exOut.resultSrc == resAlu
              && exOut.rd != '0)
    ) else begin
        $error("non-writing instruction carries a destination register");
        failCount = failCount + 1;
    end

endmodule

bind decodeExecute decodeExecute_properties props (
    .clk      (clk),
    .arstN    (arstN),
    .flush    (redirect),
    .deOut    (deOut),
    .exOut    (exOut),
    .redirect (redirect)
);

//--- tests/decodeExecute_tb.sv
`timescale 1ns/1ns

module decodeExecute_tb import rvPkg::*;;

    localparam int instrTotal = 300;      // Upper bound on driven cycles
    localparam int periodNs   = 8;

    typedef struct packed {
        logic [31:0]     due;
        logic            chkAlu;
        logic            redir;
        logic [xlen-1:0] rpc;
        exResultT        ex;
    } expT;

    logic clk, arstN, instrValid, wbEn, redirect;
    logic [xlen-1:0] instr, pc, wbData, redirectPc;
    logic [regAddrWidth-1:0] wbAddr;
    exResultT exOut;

    logic [xlen-1:0] mirror [32];         // Expected register file contents
    logic [31:0] rngState = 32'd95;
    logic [xlen-1:0] pcNext = 32'h0000_1000;
    logic flushNext = 1'b0;
    expT q [$];
    int negCount = 0;
    int checks = 0, mismatches = 0, testErrs = 0, testsRun = 0, testsFailed = 0;
    string testName = "reset";

    tbClock #(.periodNs(periodNs), .resetCycles(8)) uClock (.clk(clk), .arstN(arstN));

    decodeExecute #(.resetPc(32'h0000_0000)) DUT (
        .clk (clk), .arstN (arstN), .instrValid (instrValid), .instr (instr), .pc (pc),
        .wbEn (wbEn), .wbAddr (wbAddr), .wbData (wbData),
        .exOut (exOut), .redirect (redirect), .redirectPc (redirectPc)
    );

    function automatic logic [31:0] nextRand();
        logic [31:0] x;
        x = rngState;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rngState = x;
        return x;
    endfunction

    function automatic logic [31:0] encR(logic [6:0] f7, logic [4:0] s2, logic [4:0] s1,
                                         logic [2:0] f3, logic [4:0] d);
        return {f7, s2, s1, f3, d, 7'h33};
    endfunction

    function automatic logic [31:0] encI(logic [11:0] im, logic [4:0] s1, logic [2:0] f3,
                                         logic [4:0] d, logic [6:0] op);
        return {im, s1, f3, d, op};
    endfunction

    function automatic logic [31:0] encS(logic [11:0] im, logic [4:0] s2, logic [4:0] s1);
        return {im[11:5], s2, s1, 3'b010, im[4:0], 7'h23};
    endfunction

    function automatic logic [31:0] encB(logic [12:0] im, logic [4:0] s2, logic [4:0] s1,
                                         logic [2:0] f3);
        return {im[12], im[10:5], s2, s1, f3, im[4:1], im[11], 7'h63};
    endfunction

    function automatic logic [31:0] encJ(logic [20:0] im, logic [4:0] d);
        return {im[20], im[10:1], im[11], im[19:12], d, 7'h6f};
    endfunction

    function automatic logic [31:0] aluCalc(logic [2:0] f3, logic alt, logic [31:0] a,
                                            logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: begin
                if (alt) return $signed(a) >>> b[4:0]; // Arithmetic, sign bit fills
                return a >> b[4:0];
            end
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic brTaken(logic [2:0] f3, logic [31:0] a, logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            3'd7: return a >= b;
            default: return 1'b0;
        endcase
    endfunction

    // Expected outcome of one instruction from the RV32I rules
    function automatic expT model(logic [31:0] ins, logic [31:0] pcv);
        expT e;
        logic [31:0] a, b, immI, immS, immB, immJ;
        logic [2:0] f3;
        a    = mirror[ins[19:15]];
        b    = mirror[ins[24:20]];
        f3   = ins[14:12];
        immI = {{20{ins[31]}}, ins[31:20]};
        immS = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        immJ = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        e = '0;
        e.ex.valid     = 1'b1;
        e.ex.pcPlus4   = pcv + 4;
        e.ex.storeData = b;
        case (ins[6:0])
            7'h33: begin
                e.ex.regWrite = 1'b1;
                e.ex.rd = ins[11:7];
                e.chkAlu = 1'b1;
                e.ex.aluResult = aluCalc(f3, ins[30], a, b);
            end
            7'h13: begin
                e.ex.regWrite = 1'b1;
                e.ex.rd = ins[11:7];
                e.chkAlu = 1'b1;
                e.ex.aluResult = aluCalc(f3, f3 == 3'd5 && ins[30], a, immI);
            end
            7'h03: begin
                e.ex.regWrite = 1'b1;
                e.ex.memRead = 1'b1;
                e.ex.resultSrc = resMem;
                e.ex.rd = ins[11:7];
                e.chkAlu = 1'b1;
                e.ex.aluResult = a + immI;
            end
            7'h23: begin
                e.ex.memWrite = 1'b1;
                e.chkAlu = 1'b1;
                e.ex.aluResult = a + immS;
            end
            7'h63: begin
                e.redir = brTaken(f3, a, b);
                e.rpc = pcv + immB;
            end
            7'h6f, 7'h67: begin
                e.ex.regWrite = 1'b1;
                e.ex.resultSrc = resPcPlus4;
                e.ex.rd = ins[11:7];
                e.redir = 1'b1;
                e.rpc = (ins[6:0] == 7'h6f) ? pcv + immJ : (a + immI) & ~32'd1;
            end
            7'h37: begin
                e.ex.regWrite = 1'b1;
                e.ex.rd = ins[11:7];
                e.chkAlu = 1'b1;
                e.ex.aluResult = {ins[31:12], 12'b0};
            end
            default: ;
        endcase
        return e;
    endfunction

    task automatic check(input string what, input logic [31:0] expV, input logic [31:0] actV);
        checks++;
        if (expV !== actV) begin
            mismatches++;
            testErrs++;
            $display("FAILED %s %s: expected %h, actual %h", testName, what, expV, actV);
        end
    endtask

    task automatic issue(input logic v, input logic [31:0] ins);
        expT e;
        @(posedge clk);
        instrValid <= v;
        instr      <= ins;
        pc         <= pcNext;
        wbEn       <= 1'b0;
        e = v ? model(ins, pcNext) : '0;
        if (flushNext) e = '0; // Squashed by the older redirect
        flushNext = e.redir;
        e.due = negCount + 2;
        q.push_back(e);
        pcNext = pcNext + 4;
    endtask

    task automatic writeReg(input logic [4:0] a, input logic [31:0] d);
        @(posedge clk);
        instrValid <= 1'b0;
        wbEn       <= 1'b1;
        wbAddr     <= a;
        wbData     <= d;
        flushNext = 1'b0;
        if (a != 0) mirror[a] = d;
    endtask

    task automatic endTest();
        while (q.size() > 0) @(negedge clk);
        testsRun++;
        if (testErrs == 0) begin
            $display("Test %s: passed", testName);
        end else begin
            testsFailed++;
            $display("Test %s: failed with %0d mismatches", testName, testErrs);
        end
        testErrs = 0;
    endtask

    always @(negedge clk) begin
        expT it;
        negCount = negCount + 1;
        if (q.size() > 0 && q[0].due == negCount) begin
            it = q.pop_front();
            check("valid", it.ex.valid, exOut.valid);
            check("redirect", it.redir, redirect);
            check("regWrite", it.ex.regWrite, exOut.regWrite);
            check("memWrite", it.ex.memWrite, exOut.memWrite);
            if (it.ex.valid) begin
                check("memRead", it.ex.memRead, exOut.memRead);
                check("resultSrc", it.ex.resultSrc, exOut.resultSrc);
                check("rd", it.ex.rd, exOut.rd);
                check("storeData", it.ex.storeData, exOut.storeData);
                check("pcPlus4", it.ex.pcPlus4, exOut.pcPlus4);
                if (it.chkAlu) check("aluResult", it.ex.aluResult, exOut.aluResult);
                if (it.redir) check("redirectPc", it.rpc, redirectPc);
            end
        end
    end

    initial begin
        #((instrTotal * 8 + 200) * periodNs);
        $display("Watchdog expired before all tests finished");
        $display("** FAIL **");
        $finish;
    end

    initial begin
        logic [31:0] r, ins;
        logic [2:0] f3;
        logic alt;
        logic [4:0] s1;
        instrValid = 1'b0;
        instr = '0;
        pc = '0;
        wbEn = 1'b0;
        wbAddr = '0;
        wbData = '0;
        for (int i = 0; i < 32; i++) mirror[i] = '0;
        @(posedge arstN);
        @(negedge clk);
        check("valid after reset", 0, exOut.valid);
        check("redirect after reset", 0, redirect);
        issue(1'b0, 32'h0);
        issue(1'b0, 32'h0);
        endTest();

        for (int a = 1; a < 32; a++) writeReg(a[4:0], nextRand());

        testName = "alu";
        for (int i = 0; i < 60; i++) begin
            r = nextRand();
            f3 = r[2:0];
            alt = r[3] && (f3 == 3'd0 || f3 == 3'd5);
            if (r[5:4] == 2'd0) ins = {r[31:12], r[11:7], 7'h37};
            else if (r[5:4] == 2'd1) ins = encR({1'b0, alt, 5'b0}, r[16:12], r[21:17], f3, r[26:22]);
            else if (f3 == 3'd1 || f3 == 3'd5)
                ins = encI({1'b0, alt, 5'b0, r[31:27]}, r[21:17], f3, r[26:22], 7'h13);
            else ins = encI(r[31:20], r[16:12], f3, r[26:22], 7'h13);
            issue(1'b1, ins);
        end
        endTest();

        testName = "load store";
        for (int i = 0; i < 20; i++) begin
            r = nextRand();
            if (r[0]) issue(1'b1, encI(r[31:20], r[16:12], 3'b010, r[11:7], 7'h03));
            else issue(1'b1, encS(r[31:20], r[11:7], r[16:12]));
        end
        endTest();

        testName = "branch jump";
        for (int k = 0; k < 6; k++) begin
            f3 = (k < 2) ? k[2:0] : k[2:0] + 3'd2;
            for (int i = 0; i < 6; i++) begin
                r = nextRand();
                s1 = r[16:12];
                issue(1'b1, encB({r[31:20], 1'b0}, r[1:0] == 0 ? s1 : r[21:17], s1, f3));
                issue(1'b0, 32'h0);
            end
        end
        for (int i = 0; i < 8; i++) begin
            r = nextRand();
            if (i < 4) issue(1'b1, encJ({r[31:12], 1'b0}, r[11:7]));
            else issue(1'b1, encI(r[31:20], r[16:12], 3'b000, r[11:7], 7'h67));
            issue(1'b0, 32'h0);
        end
        endTest();

        testName = "flush";
        issue(1'b1, encJ(21'd64, 5'd1));
        issue(1'b1, encI(12'd5, 5'd2, 3'b000, 5'd3, 7'h13)); // Must come out empty
        issue(1'b1, encB(13'd32, 5'd4, 5'd4, 3'b001));       // bne never taken
        issue(1'b1, encI(12'd7, 5'd2, 3'b000, 5'd3, 7'h13));
        endTest();

        testName = "x0";
        writeReg(5'd0, 32'hdead_beef);
        issue(1'b1, encR(7'd0, 5'd0, 5'd0, 3'b000, 5'd7));
        issue(1'b1, encS(12'd8, 5'd0, 5'd0));
        endTest();

        $display("Tests run: %0d, tests failed: %0d, checks: %0d, mismatches: %0d, %s %0d",
                 testsRun, testsFailed, checks, mismatches, "assertion failures:",
                 DUT.props.failCount);
        if (mismatches == 0 && DUT.props.failCount == 0) begin
            $display("** PASS **");
        end else begin
            $display("** FAIL **");
        end
        $finish;
    end

endmodule

//--- tests/tbClock.sv
`timescale 1ns/1ns

module tbClock #(
    parameter int periodNs    = 8,
    parameter int resetCycles = 8
) (
    output logic clk,
    output logic arstN
);

    initial clk = 1'b0;
    always #(periodNs / 2) clk = ~clk;

    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        arstN <= 1'b1; // Release on an edge, like the stimulus
    end

endmodule
